/* verilog/be_pkg.sv */
// back end shared definitions
// widths, RV32I opcode and funct encodings, the instruction word views
// and the decoded operation codes carried in each issue entry

package be_pkg;

	localparam int XLEN = 32;
	localparam int REG_AW = 5;
	localparam int ALU_OP_W = 4;

	// major opcodes
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT = 7'b0100000;

	// decoded operation codes
	localparam logic [ALU_OP_W-1:0] OP_ADD = 4'd0;
	localparam logic [ALU_OP_W-1:0] OP_SUB = 4'd1;
	localparam logic [ALU_OP_W-1:0] OP_AND = 4'd2;
	localparam logic [ALU_OP_W-1:0] OP_OR = 4'd3;
	localparam logic [ALU_OP_W-1:0] OP_XOR = 4'd4;
	localparam logic [ALU_OP_W-1:0] OP_SLT = 4'd5;
	localparam logic [ALU_OP_W-1:0] OP_SLTU = 4'd6;
	localparam logic [ALU_OP_W-1:0] OP_SLL = 4'd7;
	localparam logic [ALU_OP_W-1:0] OP_SRL = 4'd8;
	localparam logic [ALU_OP_W-1:0] OP_SRA = 4'd9;
	localparam logic [ALU_OP_W-1:0] OP_BEQ = 4'd10;
	localparam logic [ALU_OP_W-1:0] OP_BNE = 4'd11;
	localparam logic [ALU_OP_W-1:0] OP_BLT = 4'd12;
	localparam logic [ALU_OP_W-1:0] OP_BGE = 4'd13;

	// B-type offset sits in imm[11:5] and rd of the I/B view
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} ib;
	} instr_u;

	// {op, rd, rs1, rs2, use_imm, imm, pc, is_br}
	localparam int DEC_W = ALU_OP_W + 3 * REG_AW + 1 + 2 * XLEN + 1;

endpackage

/* verilog/issue_fifo.sv */
// issue FIFO of decoded entries
// circular buffer with an occupancy count, emptied by a branch flush

`timescale 1ns/100ps

module issue_fifo #(
	parameter int ISSUE_DP = 4
) (
	input  logic                      CLK,
	input  logic                      i_rst_n,
	input  logic                      i_push,
	input  logic [be_pkg::DEC_W-1:0]  i_entry,
	input  logic                      i_pop,
	input  logic                      i_flush,
	output logic [be_pkg::DEC_W-1:0]  o_entry,
	output logic                      o_full,
	output logic                      o_empty
);

	localparam int AW = $clog2(ISSUE_DP);

	logic [be_pkg::DEC_W-1:0]  mem [ISSUE_DP];
	logic [AW-1:0]             rd_ptr;
	logic [AW-1:0]             wr_ptr;
	logic [AW:0]               count;
	logic                      do_push;
	logic                      do_pop;

	assign do_push = i_push & ~o_full;
	assign do_pop = i_pop & ~o_empty;

	assign o_full = count == (AW+1)'(ISSUE_DP);
	assign o_empty = count == '0;
	assign o_entry = mem[rd_ptr];

	always_ff @(posedge CLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else if (i_flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous push and pop leaves the count unchanged
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr] <= i_entry;
	end

endmodule

/* verilog/dispatch.sv */
// decode stage
// pops one word from the instruction FIFO, decodes it into an issue entry
// and holds that entry until the issue FIFO has room

`timescale 1ns/100ps

module dispatch (
	input  logic                       CLK,
	input  logic                       i_rst_n,
	input  logic                       i_instr_fifo_empty,
	input  logic [2*be_pkg::XLEN-1:0]  i_micro_instr,
	input  logic                       i_fifo_full,
	input  logic                       i_flush,
	output logic                       o_instr_fifo_pop,
	output logic                       o_push,
	output logic [be_pkg::DEC_W-1:0]   o_entry,
	output logic                       o_illegal
);

	be_pkg::instr_u                  ins;
	logic [be_pkg::XLEN-1:0]         pc;
	logic [be_pkg::ALU_OP_W-1:0]     dec_op;
	logic [be_pkg::REG_AW-1:0]       dec_rd;
	logic [be_pkg::REG_AW-1:0]       dec_rs1;
	logic [be_pkg::REG_AW-1:0]       dec_rs2;
	logic                            dec_use_imm;
	logic [be_pkg::XLEN-1:0]         dec_imm;
	logic                            dec_is_br;
	logic                            dec_legal;
	logic                            hold_valid;
	logic [be_pkg::DEC_W-1:0]        hold_entry;

	function automatic logic [be_pkg::ALU_OP_W-1:0] alu_sel(input logic [2:0] f3,
			input logic alt);
		case (f3)
			be_pkg::F3_ADD:  alu_sel = alt ? be_pkg::OP_SUB : be_pkg::OP_ADD;
			be_pkg::F3_SLL:  alu_sel = be_pkg::OP_SLL;
			be_pkg::F3_SLT:  alu_sel = be_pkg::OP_SLT;
			be_pkg::F3_SLTU: alu_sel = be_pkg::OP_SLTU;
			be_pkg::F3_XOR:  alu_sel = be_pkg::OP_XOR;
			be_pkg::F3_SR:   alu_sel = alt ? be_pkg::OP_SRA : be_pkg::OP_SRL;
			be_pkg::F3_OR:   alu_sel = be_pkg::OP_OR;
			default:         alu_sel = be_pkg::OP_AND;
		endcase
	endfunction

	assign pc = i_micro_instr[2*be_pkg::XLEN-1:be_pkg::XLEN];
	assign ins = i_micro_instr[be_pkg::XLEN-1:0];

	always_comb begin
		dec_op = be_pkg::OP_ADD;
		dec_rd = ins.r.rd;
		dec_rs1 = ins.r.rs1;
		dec_rs2 = ins.r.rs2;
		dec_use_imm = 1'b0;
		dec_imm = '0;
		dec_is_br = 1'b0;
		dec_legal = 1'b0;
		case (ins.r.opcode)
			be_pkg::OPC_OP: begin
				dec_op = alu_sel(ins.r.funct3, ins.r.funct7[5]);
				dec_legal = (ins.r.funct7 == be_pkg::F7_BASE) ||
					(ins.r.funct7 == be_pkg::F7_ALT &&
					(ins.r.funct3 == be_pkg::F3_ADD || ins.r.funct3 == be_pkg::F3_SR));
			end
			be_pkg::OPC_OP_IMM: begin
				// only shift right reads funct7 as an opcode extension
				dec_op = alu_sel(ins.ib.funct3,
					ins.r.funct7[5] && ins.ib.funct3 == be_pkg::F3_SR);
				dec_rs2 = '0;
				dec_use_imm = 1'b1;
				dec_imm = {{(be_pkg::XLEN-12){ins.ib.imm[11]}}, ins.ib.imm};
				dec_legal = (ins.ib.funct3 != be_pkg::F3_SLL && ins.ib.funct3 != be_pkg::F3_SR) ||
					(ins.r.funct7 == be_pkg::F7_BASE) ||
					(ins.r.funct7 == be_pkg::F7_ALT && ins.ib.funct3 == be_pkg::F3_SR);
			end
			be_pkg::OPC_BRANCH: begin
				dec_rd = '0;
				dec_is_br = 1'b1;
				dec_imm = {{(be_pkg::XLEN-13){ins.ib.imm[11]}}, ins.ib.imm[11], ins.ib.rd[0],
					ins.ib.imm[10:5], ins.ib.rd[4:1], 1'b0};
				dec_legal = 1'b1;
				case (ins.ib.funct3)
					be_pkg::F3_BEQ: dec_op = be_pkg::OP_BEQ;
					be_pkg::F3_BNE: dec_op = be_pkg::OP_BNE;
					be_pkg::F3_BLT: dec_op = be_pkg::OP_BLT;
					be_pkg::F3_BGE: dec_op = be_pkg::OP_BGE;
					default:        dec_legal = 1'b0;
				endcase
			end
			default: dec_legal = 1'b0;
		endcase
	end

	// room in the holding register when empty or draining this cycle
	assign o_push = hold_valid & ~i_fifo_full & ~i_flush;
	assign o_instr_fifo_pop = ~i_instr_fifo_empty & ~i_flush & (~hold_valid | o_push);
	assign o_entry = hold_entry;

	always_ff @(posedge CLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			hold_valid <= 1'b0;
			o_illegal <= 1'b0;
		end else begin
			o_illegal <= o_instr_fifo_pop & ~dec_legal;
			if (i_flush)
				hold_valid <= 1'b0;
			else if (o_instr_fifo_pop)
				hold_valid <= dec_legal;
			else if (o_push)
				hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (o_instr_fifo_pop)
			hold_entry <= {dec_op, dec_rd, dec_rs1, dec_rs2, dec_use_imm, dec_imm, pc, dec_is_br};
	end

endmodule

/* verilog/execute.sv */
// execute stage
// pops the issue FIFO head, resolves operands with bypass, runs the ALU
// or resolves a branch, and registers the result and branch outcome

`timescale 1ns/100ps

module execute (
	input  logic                       CLK,
	input  logic                       i_rst_n,
	input  logic                       i_empty,
	input  logic [be_pkg::DEC_W-1:0]   i_entry,
	input  logic [be_pkg::XLEN-1:0]    i_rs1_data,
	input  logic [be_pkg::XLEN-1:0]    i_rs2_data,
	output logic                       o_pop,
	output logic [be_pkg::REG_AW-1:0]  o_rs1_addr,
	output logic [be_pkg::REG_AW-1:0]  o_rs2_addr,
	output logic                       o_wb_valid,
	output logic [be_pkg::REG_AW-1:0]  o_wb_rd,
	output logic [be_pkg::XLEN-1:0]    o_wb_data,
	output logic                       o_br_valid,
	output logic                       o_br_taken,
	output logic [be_pkg::XLEN-1:0]    o_br_target,
	output logic                       o_flush
);

	logic [be_pkg::ALU_OP_W-1:0]  e_op;
	logic [be_pkg::REG_AW-1:0]    e_rd;
	logic [be_pkg::REG_AW-1:0]    e_rs1;
	logic [be_pkg::REG_AW-1:0]    e_rs2;
	logic                         e_use_imm;
	logic [be_pkg::XLEN-1:0]      e_imm;
	logic [be_pkg::XLEN-1:0]      e_pc;
	logic                         e_is_br;
	logic [be_pkg::XLEN-1:0]      op_a;
	logic [be_pkg::XLEN-1:0]      rs2_val;
	logic [be_pkg::XLEN-1:0]      op_b;
	logic [be_pkg::XLEN-1:0]      alu_res;
	logic                         taken;

	assign {e_op, e_rd, e_rs1, e_rs2, e_use_imm, e_imm, e_pc, e_is_br} = i_entry;

	// hold off one cycle while the younger entries are flushed
	assign o_pop = ~i_empty & ~o_flush;

	assign o_rs1_addr = e_rs1;
	assign o_rs2_addr = e_rs2;

	// the register file is written one edge after the result registers
	assign op_a = (o_wb_valid && o_wb_rd == e_rs1 && e_rs1 != '0) ? o_wb_data : i_rs1_data;
	assign rs2_val = (o_wb_valid && o_wb_rd == e_rs2 && e_rs2 != '0) ? o_wb_data : i_rs2_data;
	assign op_b = e_use_imm ? e_imm : rs2_val;

	always_comb begin
		case (e_op)
			be_pkg::OP_ADD:  alu_res = op_a + op_b;
			be_pkg::OP_SUB:  alu_res = op_a - op_b;
			be_pkg::OP_AND:  alu_res = op_a & op_b;
			be_pkg::OP_OR:   alu_res = op_a | op_b;
			be_pkg::OP_XOR:  alu_res = op_a ^ op_b;
			be_pkg::OP_SLT:  alu_res = {{(be_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			be_pkg::OP_SLTU: alu_res = {{(be_pkg::XLEN-1){1'b0}}, op_a < op_b};
			be_pkg::OP_SLL:  alu_res = op_a << op_b[4:0];
			be_pkg::OP_SRL:  alu_res = op_a >> op_b[4:0];
			be_pkg::OP_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
			default:         alu_res = '0;
		endcase
	end

	always_comb begin
		case (e_op)
			be_pkg::OP_BEQ: taken = op_a == rs2_val;
			be_pkg::OP_BNE: taken = op_a != rs2_val;
			be_pkg::OP_BLT: taken = $signed(op_a) < $signed(rs2_val);
			be_pkg::OP_BGE: taken = $signed(op_a) >= $signed(rs2_val);
			default:        taken = 1'b0;
		endcase
	end

	always_ff @(posedge CLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_wb_valid <= 1'b0;
			o_br_valid <= 1'b0;
			o_br_taken <= 1'b0;
			o_flush <= 1'b0;
		end else begin
			o_wb_valid <= o_pop & ~e_is_br;
			o_br_valid <= o_pop & e_is_br;
			o_br_taken <= o_pop & e_is_br & taken;
			o_flush <= o_pop & e_is_br & taken;
		end
	end

	always_ff @(posedge CLK) begin
		if (o_pop) begin
			o_wb_rd <= e_rd;
			o_wb_data <= alu_res;
			o_br_target <= e_pc + e_imm;
		end
	end

endmodule

/* verilog/write_back.sv */
// result stage
// owns the integer register file, writes execute results on a valid pulse
// and serves two combinational read ports with x0 tied to zero

`timescale 1ns/100ps

module write_back (
	input  logic                       CLK,
	input  logic                       i_rst_n,
	input  logic                       i_wb_valid,
	input  logic [be_pkg::REG_AW-1:0]  i_wb_rd,
	input  logic [be_pkg::XLEN-1:0]    i_wb_data,
	input  logic [be_pkg::REG_AW-1:0]  i_rs1_addr,
	input  logic [be_pkg::REG_AW-1:0]  i_rs2_addr,
	output logic [be_pkg::XLEN-1:0]    o_rs1_data,
	output logic [be_pkg::XLEN-1:0]    o_rs2_data
);

	localparam int NREG = 2 ** be_pkg::REG_AW;

	logic [be_pkg::XLEN-1:0]  regs [1:NREG-1];

	always_ff @(posedge CLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 1; i < NREG; i++)
				regs[i] <= '0;
		end else if (i_wb_valid && i_wb_rd != '0) begin
			regs[i_wb_rd] <= i_wb_data;
		end
	end

	// x0 has no storage
	assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
	assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

/* verilog/back_end.sv */
// in-order integer back end
// decode, issue FIFO, execute and register file result stage;
// branches are predicted not taken and a taken one flushes younger work

`timescale 1ns/100ps

module back_end #(
	parameter int ISSUE_DP = 4
) (
	input  logic                       CLK,
	input  logic                       i_rst_n,
	input  logic                       i_instr_fifo_empty,
	input  logic [2*be_pkg::XLEN-1:0]  i_micro_instr,
	output logic                       o_instr_fifo_pop,
	output logic                       o_illegal,
	output logic                       o_wb_valid,
	output logic [be_pkg::REG_AW-1:0]  o_wb_rd,
	output logic [be_pkg::XLEN-1:0]    o_wb_data,
	output logic                       o_br_valid,
	output logic                       o_br_taken,
	output logic [be_pkg::XLEN-1:0]    o_br_target,
	output logic                       o_flush
);

	logic                       dsp_push;
	logic [be_pkg::DEC_W-1:0]   dsp_entry;
	logic                       fifo_full;
	logic                       fifo_empty;
	logic [be_pkg::DEC_W-1:0]   fifo_entry;
	logic                       exe_pop;
	logic [be_pkg::REG_AW-1:0]  rs1_addr;
	logic [be_pkg::REG_AW-1:0]  rs2_addr;
	logic [be_pkg::XLEN-1:0]    rs1_data;
	logic [be_pkg::XLEN-1:0]    rs2_data;

	dispatch i_dispatch (
		.CLK                (CLK),
		.i_rst_n            (i_rst_n),
		.i_instr_fifo_empty (i_instr_fifo_empty),
		.i_micro_instr      (i_micro_instr),
		.i_fifo_full        (fifo_full),
		.i_flush            (o_flush),
		.o_instr_fifo_pop   (o_instr_fifo_pop),
		.o_push             (dsp_push),
		.o_entry            (dsp_entry),
		.o_illegal          (o_illegal)
	);

	issue_fifo #(
		.ISSUE_DP (ISSUE_DP)
	) i_issue_fifo (
		.CLK     (CLK),
		.i_rst_n (i_rst_n),
		.i_push  (dsp_push),
		.i_entry (dsp_entry),
		.i_pop   (exe_pop),
		.i_flush (o_flush),
		.o_entry (fifo_entry),
		.o_full  (fifo_full),
		.o_empty (fifo_empty)
	);

	execute i_execute (
		.CLK         (CLK),
		.i_rst_n     (i_rst_n),
		.i_empty     (fifo_empty),
		.i_entry     (fifo_entry),
		.i_rs1_data  (rs1_data),
		.i_rs2_data  (rs2_data),
		.o_pop       (exe_pop),
		.o_rs1_addr  (rs1_addr),
		.o_rs2_addr  (rs2_addr),
		.o_wb_valid  (o_wb_valid),
		.o_wb_rd     (o_wb_rd),
		.o_wb_data   (o_wb_data),
		.o_br_valid  (o_br_valid),
		.o_br_taken  (o_br_taken),
		.o_br_target (o_br_target),
		.o_flush     (o_flush)
	);

	write_back i_write_back (
		.CLK        (CLK),
		.i_rst_n    (i_rst_n),
		.i_wb_valid (o_wb_valid),
		.i_wb_rd    (o_wb_rd),
		.i_wb_data  (o_wb_data),
		.i_rs1_addr (rs1_addr),
		.i_rs2_addr (rs2_addr),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

endmodule

/* dv/back_end_chk.sv */
// protocol assertions on the back end top level ports
// bound into every back_end instance

`timescale 1ns/100ps

module back_end_chk (
	input logic CLK,
	input logic i_rst_n,
	input logic i_instr_fifo_empty,
	input logic o_instr_fifo_pop,
	input logic o_wb_valid,
	input logic o_br_valid,
	input logic o_br_taken,
	input logic o_flush
);

	a_pop_empty: assert property (@(posedge CLK) disable iff (!i_rst_n)
		o_instr_fifo_pop |-> !i_instr_fifo_empty)
		else $error("instruction FIFO popped while empty");

	a_wb_br: assert property (@(posedge CLK) disable iff (!i_rst_n)
		!(o_wb_valid && o_br_valid))
		else $error("result and branch pulse in the same cycle");

	a_flush_taken: assert property (@(posedge CLK) disable iff (!i_rst_n)
		o_flush |-> (o_br_valid && o_br_taken))
		else $error("flush without a taken branch");

	// younger work is squashed, so the next cycle retires nothing
	a_flush_wb: assert property (@(posedge CLK) disable iff (!i_rst_n)
		o_flush |=> !o_wb_valid)
		else $error("result pulse right after a flush");

endmodule

bind back_end back_end_chk i_chk (
	.CLK                (CLK),
	.i_rst_n            (i_rst_n),
	.i_instr_fifo_empty (i_instr_fifo_empty),
	.o_instr_fifo_pop   (o_instr_fifo_pop),
	.o_wb_valid         (o_wb_valid),
	.o_br_valid         (o_br_valid),
	.o_br_taken         (o_br_taken),
	.o_flush            (o_flush)
);

/* dv/tb_back_end.sv */
// testbench for the in-order back end
// feeds programs from the cases file through an instruction FIFO model
// and checks every result and branch pulse against an ISA model

`timescale 1ns/100ps

module tb_back_end #(
	parameter int ISSUE_DP = 4
);

	localparam int PROG_DP = 64;
	localparam int MAX_STEPS = 512;
	localparam int TIMEOUT = 200;

	logic         CLK = 1'b0;
	logic         i_rst_n = 1'b0;
	logic         i_instr_fifo_empty = 1'b1;
	logic [63:0]  i_micro_instr = '0;
	logic         o_instr_fifo_pop;
	logic         o_illegal;
	logic         o_wb_valid;
	logic [4:0]   o_wb_rd;
	logic [31:0]  o_wb_data;
	logic         o_br_valid;
	logic         o_br_taken;
	logic [31:0]  o_br_target;
	logic         o_flush;

	logic [63:0]  prog [PROG_DP];
	int           prog_len = 0;
	logic [31:0]  fpc = '0;
	logic         run = 1'b0;
	integer       seed = 32'h72b5;
	int           ill_seen = 0;
	int           ill_exp = 0;
	logic         exp_is_br [$];
	logic [4:0]   exp_rd [$];
	logic         exp_taken [$];
	logic [31:0]  exp_val [$];

	back_end #(
		.ISSUE_DP (ISSUE_DP)
	) i_dut (
		.CLK                (CLK),
		.i_rst_n            (i_rst_n),
		.i_instr_fifo_empty (i_instr_fifo_empty),
		.i_micro_instr      (i_micro_instr),
		.o_instr_fifo_pop   (o_instr_fifo_pop),
		.o_illegal          (o_illegal),
		.o_wb_valid         (o_wb_valid),
		.o_wb_rd            (o_wb_rd),
		.o_wb_data          (o_wb_data),
		.o_br_valid         (o_br_valid),
		.o_br_taken         (o_br_taken),
		.o_br_target        (o_br_target),
		.o_flush            (o_flush)
	);

	always #4 CLK = ~CLK;

	task automatic compare_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run aborted");
	endtask

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// walk the program in ISA order and queue every expected pulse
	task automatic build_expected;
		logic [31:0]  regs [32];
		logic [31:0]  pc;
		logic [31:0]  w;
		logic [31:0]  a;
		logic [31:0]  b;
		logic [31:0]  res;
		logic [31:0]  boff;
		logic         legal;
		logic         tk;
		int           steps;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		pc = '0;
		steps = 0;
		while ((pc >> 2) < 32'(prog_len) && steps < MAX_STEPS) begin
			w = prog[pc[7:2]][31:0];
			a = regs[w[19:15]];
			b = regs[w[24:20]];
			steps++;
			legal = 1'b0;
			if (w[6:0] == 7'h33)
				legal = w[31:25] == 7'h00 ||
					(w[31:25] == 7'h20 && (w[14:12] == 3'd0 || w[14:12] == 3'd5));
			else if (w[6:0] == 7'h13)
				legal = w[13:12] != 2'b01 || w[31:25] == 7'h00 ||
					(w[31:25] == 7'h20 && w[14]);
			else if (w[6:0] == 7'h63)
				legal = !w[13];
			if (!legal) begin
				ill_exp++;
				pc = pc + 32'd4;
			end else if (w[6:0] == 7'h63) begin
				case (w[14:12])
					3'd0: tk = a == b;
					3'd1: tk = a != b;
					3'd4: tk = $signed(a) < $signed(b);
					default: tk = $signed(a) >= $signed(b);
				endcase
				boff = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				exp_is_br.push_back(1'b1);
				exp_rd.push_back('0);
				exp_taken.push_back(tk);
				exp_val.push_back(pc + boff);
				pc = tk ? pc + boff : pc + 32'd4;
			end else begin
				if (w[6:0] == 7'h13)
					res = alu_ref(w[14:12], w[30] && w[14:12] == 3'd5, a, sext12(w[31:20]));
				else
					res = alu_ref(w[14:12], w[30], a, b);
				// x0 stays zero
				if (w[11:7] != 5'd0)
					regs[w[11:7]] = res;
				exp_is_br.push_back(1'b0);
				exp_rd.push_back(w[11:7]);
				exp_taken.push_back(1'b0);
				exp_val.push_back(res);
				pc = pc + 32'd4;
			end
		end
	endtask

	// instruction FIFO model that restarts at the branch target on flush
	always @(posedge CLK) begin : fifo_model
		logic [31:0] nxt_pc;
		if (run) begin
			nxt_pc = fpc;
			if (o_flush)
				nxt_pc = o_br_target;
			else if (o_instr_fifo_pop)
				nxt_pc = fpc + 32'd4;
			fpc <= nxt_pc;
			if ((nxt_pc >> 2) < 32'(prog_len)) begin
				i_instr_fifo_empty <= ($random(seed) & 32'd3) == 32'd0;
				i_micro_instr <= prog[nxt_pc[7:2]];
			end else begin
				i_instr_fifo_empty <= 1'b1;
				i_micro_instr <= '0;
			end
		end
	end

	always @(negedge CLK) begin
		if (run && o_illegal)
			ill_seen <= ill_seen + 1;
	end

	initial begin : main
		int wait_cnt;
		int n_exp;
		// pc field never matches its slot, so the program ends at the first gap
		for (int i = 0; i < PROG_DP; i++)
			prog[i] = {~32'(i * 4), 32'(i)};
		$readmemh("dv/back_end_cases.txt", prog);
		while (prog_len < PROG_DP && prog[prog_len][63:32] == 32'(prog_len * 4))
			prog_len++;
		if (prog_len == 0)
			abort_run("no program found in the cases file");
		build_expected();
		n_exp = exp_is_br.size();
		$display("program of %0d words, %0d pulses expected", prog_len, n_exp);
		repeat (8) @(posedge CLK);
		i_rst_n <= 1'b1;
		run <= 1'b1;
		for (int i = 0; i < n_exp; i++) begin
			wait_cnt = 0;
			@(negedge CLK);
			while (!o_wb_valid && !o_br_valid) begin
				wait_cnt++;
				if (wait_cnt > TIMEOUT)
					abort_run("timeout while waiting for a result or branch pulse");
				@(negedge CLK);
			end
			compare_val("o_br_valid", 32'(o_br_valid), 32'(exp_is_br[i]));
			compare_val("o_flush", 32'(o_flush), 32'(exp_is_br[i] && exp_taken[i]));
			if (exp_is_br[i]) begin
				compare_val("o_br_taken", 32'(o_br_taken), 32'(exp_taken[i]));
				compare_val("o_br_target", o_br_target, exp_val[i]);
			end else begin
				compare_val("o_wb_rd", 32'(o_wb_rd), 32'(exp_rd[i]));
				compare_val("o_wb_data", o_wb_data, exp_val[i]);
			end
		end
		// nothing else may retire once the program is done
		repeat (TIMEOUT) begin
			@(negedge CLK);
			if (o_wb_valid || o_br_valid)
				abort_run("extra result or branch pulse after the last instruction");
		end
		compare_val("o_illegal count", 32'(ill_seen), 32'(ill_exp));
		$display("TB PASSED");
		$finish;
	end

endmodule

/* dv/back_end_cases.txt */
// one instruction per line: pc and machine word as {pc_word}, 64 bits
// the first lines seed registers with addi, the program ends at the first gap
00000000_00500093 // addi x1, x0, 5
00000004_ffd00113 // addi x2, x0, -3
00000008_7ff00193 // addi x3, x0, 0x7ff
0000000c_00208233 // add  x4, x1, x2
00000010_403202b3 // sub  x5, x4, x3
00000014_0012a333 // slt  x6, x5, x1
00000018_0012b3b3 // sltu x7, x5, x1
0000001c_00209433 // sll  x8, x1, x2
00000020_4012d4b3 // sra  x9, x5, x1
00000024_0042d513 // srli x10, x5, 4
00000028_fff14593 // xori x11, x2, -1
0000002c_02208633 // mul  x12, x1, x2 is not supported
00000030_00908013 // addi x0, x1, 9
00000034_00100633 // add  x12, x0, x1
00000038_10066693 // ori  x13, x12, 0x100
0000003c_0f06f713 // andi x14, x13, 0xf0
00000040_00c08663 // beq  x1, x12, +12 taken
00000044_00100793 // addi x15, x0, 1 wrong path
00000048_00200793 // addi x15, x0, 2 wrong path
0000004c_00c09463 // bne  x1, x12, +8 not taken
00000050_00114463 // blt  x2, x1, +8 taken
00000054_00300793 // addi x15, x0, 3 wrong path
00000058_00115463 // bge  x2, x1, +8 not taken
0000005c_0020d463 // bge  x1, x2, +8 taken
00000060_00400793 // addi x15, x0, 4 wrong path
00000064_00978833 // add  x16, x15, x9
00000068_ffe12893 // slti x17, x2, -2
0000006c_fff0b913 // sltiu x18, x1, -1
00000070_40115993 // srai x19, x2, 1
00000074_01e99a13 // slli x20, x19, 30

/* vlog.f */
verilog/be_pkg.sv
verilog/issue_fifo.sv
verilog/dispatch.sv
verilog/execute.sv
verilog/write_back.sv
verilog/back_end.sv
dv/back_end_chk.sv
dv/tb_back_end.sv

/* Makefile */
# Verilator build, run and lint for the back end testbench
# override on the command line, e.g. make ISSUE_DP=4

VERILATOR ?= verilator
TOP       ?= tb_back_end
ISSUE_DP  ?= 2
BUILD_DIR ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert -j 0
SIM       ?= $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GISSUE_DP=$(ISSUE_DP) --Mdir $(BUILD_DIR)

# a failing run ends in $$fatal, so the exit status carries the result
run: build
	./$(SIM)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
